// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

	// cache geometry, 2 ways of 64 sets with 8-word lines
	localparam int WORD_W = 32;
	localparam int NUM_WAYS = 2;
	localparam int WORDS_PER_LINE = 8;
	localparam int NUM_SETS = 64;
	localparam int NUM_BYTES = WORD_W / 8;

	// address field widths
	localparam int BYTE_W = 2;
	localparam int OFFSET_W = 3;
	localparam int INDEX_W = 6;
	localparam int TAG_W = WORD_W - INDEX_W - OFFSET_W - BYTE_W;

	// word address inside one way of the data store
	localparam int LINE_ADDR_W = INDEX_W + OFFSET_W;
	localparam int DATA_DEPTH = NUM_SETS * WORDS_PER_LINE;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [TAG_W-1:0] tag_t;

	// request address, whole word or split into its cache fields
	typedef union packed {
		word_t addr;
		struct packed {
			tag_t                tag;
			index_t              index;
			offset_t             offset;
			logic [BYTE_W-1:0]   byte_sel;
		} fld;
	} dcache_addr_u;

	typedef enum logic [2:0] {
		SWEEP,
		LOOKUP,
		WB_READ,
		WB_SEND,
		REFILL_REQ,
		REFILL,
		REPLAY
	} ctrl_state_e;

endpackage

`default_nettype wire

// ==== rtl/dcache_ctrl_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl_fsm (
	input  wire                     i_clk,
	input  wire                     i_rst,
	input  wire                     i_lookup_valid,
	input  wire                     i_hit,
	input  wire                     i_victim_valid,
	input  wire                     i_cnt_last,
	input  wire                     i_mem_rd_valid,
	output dcache_pkg::ctrl_state_e o_state,
	output logic                    o_busy,
	output logic                    o_cnt_clear,
	output logic                    o_cnt_step,
	output logic                    o_sweep_en,
	output logic                    o_tag_we,
	output logic                    o_fill_we,
	output logic                    o_wb_rd,
	output logic                    o_wb_valid,
	output logic                    o_rd_req,
	output logic                    o_replay
);

	dcache_pkg::ctrl_state_e state_q;
	dcache_pkg::ctrl_state_e state_d;
	logic miss;
	logic replay_sent_q;

	assign miss = (state_q == dcache_pkg::LOOKUP) && i_lookup_valid && !i_hit;

	// a miss stalls the CPU in the very cycle it is seen
	assign o_busy = (state_q != dcache_pkg::LOOKUP) || miss;
	assign o_state = state_q;

	always_comb begin
		state_d = state_q;
		o_cnt_clear = 1'b0;
		o_cnt_step = 1'b0;
		o_sweep_en = 1'b0;
		o_tag_we = 1'b0;
		o_fill_we = 1'b0;
		o_wb_rd = 1'b0;
		o_rd_req = 1'b0;
		o_replay = 1'b0;
		case (state_q)
			dcache_pkg::SWEEP: begin
				// one set invalidated per cycle
				o_sweep_en = 1'b1;
				o_tag_we = 1'b1;
				o_cnt_step = 1'b1;
				if (i_cnt_last) begin
					state_d = dcache_pkg::LOOKUP;
				end
			end
			dcache_pkg::LOOKUP: begin
				o_cnt_clear = 1'b1;
				if (miss) begin
					state_d = i_victim_valid ? dcache_pkg::WB_READ : dcache_pkg::REFILL_REQ;
				end
			end
			dcache_pkg::WB_READ: begin
				o_wb_rd = 1'b1;
				o_cnt_step = 1'b1;
				if (i_cnt_last) begin
					state_d = dcache_pkg::WB_SEND;
				end
			end
			dcache_pkg::WB_SEND: begin
				// last write beat leaves here
				o_cnt_clear = 1'b1;
				state_d = dcache_pkg::REFILL_REQ;
			end
			dcache_pkg::REFILL_REQ: begin
				o_rd_req = 1'b1;
				o_cnt_clear = 1'b1;
				state_d = dcache_pkg::REFILL;
			end
			dcache_pkg::REFILL: begin
				if (i_mem_rd_valid) begin
					o_fill_we = 1'b1;
					o_cnt_step = 1'b1;
					if (i_cnt_last) begin
						// line complete, tag becomes valid
						o_tag_we = 1'b1;
						state_d = dcache_pkg::REPLAY;
					end
				end
			end
			dcache_pkg::REPLAY: begin
				// issue, compare, then answer before going back to lookup
				if (!replay_sent_q) begin
					o_replay = 1'b1;
				end else if (!i_lookup_valid) begin
					state_d = dcache_pkg::LOOKUP;
				end
			end
			default: begin
				state_d = dcache_pkg::SWEEP;
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q <= dcache_pkg::SWEEP;
			replay_sent_q <= 1'b0;
			o_wb_valid <= 1'b0;
		end else begin
			state_q <= state_d;
			replay_sent_q <= (state_q == dcache_pkg::REPLAY);
			// write beat follows its data store read by one cycle
			o_wb_valid <= o_wb_rd;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/line_word_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_word_counter (
	input  wire                i_clk,
	input  wire                i_rst,
	input  wire                i_clear,
	input  wire                i_step,
	input  wire                i_sweep,
	output dcache_pkg::index_t o_count,
	output logic               o_last
);

	// set index during the sweep, word offset in its low bits during bursts
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_count <= '0;
		end else if (i_clear) begin
			o_count <= '0;
		end else if (i_step) begin
			o_count <= o_count + 1'b1;
		end
	end

	// last set of the sweep, or last word of a line
	always_comb begin
		if (i_sweep) begin
			o_last = &o_count;
		end else begin
			o_last = &o_count[dcache_pkg::OFFSET_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tag_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module tag_store (
	input  wire                i_clk,
	input  wire                i_rst,
	input  wire dcache_pkg::index_t i_rd_index,
	input  wire dcache_pkg::tag_t   i_cmp_tag,
	input  wire                i_we,
	input  wire                i_we_way,
	input  wire dcache_pkg::index_t i_wr_index,
	input  wire dcache_pkg::tag_t   i_wr_tag,
	input  wire                i_sweep,
	output logic               o_hit,
	output logic               o_hit_way,
	output dcache_pkg::tag_t   o_way_tag,
	output logic               o_victim_valid
);

	logic [dcache_pkg::NUM_WAYS-1:0] way_hit;
	logic [dcache_pkg::NUM_WAYS-1:0] way_valid;
	dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0] way_tag;

	for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
		logic valid_mem [dcache_pkg::NUM_SETS];
		dcache_pkg::tag_t tag_mem [dcache_pkg::NUM_SETS];
		dcache_pkg::tag_t rd_tag_q;
		logic rd_valid_q;
		logic way_we;

		// the sweep clears both ways of a set at once
		assign way_we = i_we && (i_sweep || (i_we_way == 1'(w)));

		always_ff @(posedge i_clk) begin
			if (way_we) begin
				valid_mem[i_wr_index] <= !i_sweep;
				tag_mem[i_wr_index] <= i_wr_tag;
			end
			rd_tag_q <= tag_mem[i_rd_index];
		end

		always_ff @(posedge i_clk) begin
			if (i_rst) begin
				rd_valid_q <= 1'b0;
			end else begin
				rd_valid_q <= valid_mem[i_rd_index];
			end
		end

		assign way_hit[w] = rd_valid_q && (rd_tag_q == i_cmp_tag);
		assign way_valid[w] = rd_valid_q;
		assign way_tag[w] = rd_tag_q;
	end

	assign o_hit = |way_hit;
	assign o_hit_way = way_hit[1];

	// victim view, used for the writeback address
	assign o_way_tag = way_tag[i_we_way];
	assign o_victim_valid = way_valid[i_we_way];

endmodule

`default_nettype wire

// ==== rtl/data_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_store (
	input  wire                      i_clk,
	input  wire dcache_pkg::index_t  i_rd_index,
	input  wire dcache_pkg::offset_t i_rd_offset,
	input  wire                      i_we,
	input  wire                      i_we_way,
	input  wire dcache_pkg::index_t  i_wr_index,
	input  wire dcache_pkg::offset_t i_wr_offset,
	input  wire [dcache_pkg::NUM_BYTES-1:0] i_byte_en,
	input  wire dcache_pkg::word_t   i_wdata,
	input  wire                      i_rd_way,
	output dcache_pkg::word_t        o_rdata
);

	logic [dcache_pkg::LINE_ADDR_W-1:0] rd_addr;
	logic [dcache_pkg::LINE_ADDR_W-1:0] wr_addr;
	logic same_addr;
	dcache_pkg::word_t [dcache_pkg::NUM_WAYS-1:0] rd_ways;

	assign rd_addr = {i_rd_index, i_rd_offset};
	assign wr_addr = {i_wr_index, i_wr_offset};
	assign same_addr = (rd_addr == wr_addr);

	for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
		dcache_pkg::word_t mem [dcache_pkg::DATA_DEPTH];
		dcache_pkg::word_t rd_q;
		logic way_we;

		assign way_we = i_we && (i_we_way == 1'(w));

		always_ff @(posedge i_clk) begin
			for (int b = 0; b < dcache_pkg::NUM_BYTES; b++) begin
				if (way_we && i_byte_en[b]) begin
					mem[wr_addr][8*b +: 8] <= i_wdata[8*b +: 8];
				end
				// written bytes bypass the array on a same-cycle match
				if (way_we && same_addr && i_byte_en[b]) begin
					rd_q[8*b +: 8] <= i_wdata[8*b +: 8];
				end else begin
					rd_q[8*b +: 8] <= mem[rd_addr][8*b +: 8];
				end
			end
		end

		assign rd_ways[w] = rd_q;
	end

	// way is picked after the read, once the compare has finished
	assign o_rdata = rd_ways[i_rd_way];

endmodule

`default_nettype wire

// ==== rtl/lru_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module lru_store (
	input  wire                     i_clk,
	input  wire                     i_rst,
	input  wire dcache_pkg::index_t i_index,
	input  wire                     i_touch,
	input  wire                     i_touch_way,
	output logic                    o_victim_way
);

	// one bit per set, naming the way to replace next
	logic [dcache_pkg::NUM_SETS-1:0] lru_q;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			lru_q <= '0;
		end else if (i_touch) begin
			// the other way becomes the older one
			lru_q[i_index] <= !i_touch_way;
		end
	end

	assign o_victim_way = lru_q[i_index];

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
	input  wire                              i_clk,
	input  wire                              i_rst,
	input  wire                              i_req,
	input  wire dcache_pkg::word_t           i_addr,
	input  wire [dcache_pkg::NUM_BYTES-1:0]  i_wen,
	input  wire dcache_pkg::word_t           i_wdata,
	input  wire                              i_mem_rd_valid,
	input  wire dcache_pkg::word_t           i_mem_rd_data,
	output logic                             o_busy,
	output logic                             o_rvalid,
	output dcache_pkg::word_t                o_rdata,
	output logic                             o_mem_rd_req,
	output dcache_pkg::word_t                o_mem_rd_addr,
	output logic                             o_mem_wr_valid,
	output dcache_pkg::word_t                o_mem_wr_addr,
	output dcache_pkg::word_t                o_mem_wr_data
);

	function automatic dcache_pkg::word_t merge_bytes(
		input dcache_pkg::word_t old_w,
		input dcache_pkg::word_t new_w,
		input logic [dcache_pkg::NUM_BYTES-1:0] be
	);
		dcache_pkg::word_t res;
		res = old_w;
		for (int b = 0; b < dcache_pkg::NUM_BYTES; b++) begin
			if (be[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	dcache_pkg::ctrl_state_e state;
	logic cnt_clear, cnt_step, sweep_en, tag_we, fill_we;
	logic wb_rd, rd_req, replay, wb_valid;
	dcache_pkg::index_t cnt;
	logic cnt_last;
	logic hit, hit_way, victim_valid, lru_victim;
	dcache_pkg::tag_t way_tag;
	dcache_pkg::word_t ds_rdata;

	logic accept, lookup_hit, miss, hit_store;
	dcache_pkg::dcache_addr_u rq_addr, s1_addr, sv_addr, rd_line, wb_line;
	logic s1_valid;
	logic [dcache_pkg::NUM_BYTES-1:0] s1_wen, sv_wen;
	dcache_pkg::word_t s1_wdata, sv_wdata;
	logic sv_way;
	dcache_pkg::offset_t cnt_off;

	assign accept = i_req && !o_busy;
	assign lookup_hit = s1_valid && hit;
	assign miss = s1_valid && !hit && (state == dcache_pkg::LOOKUP);
	assign hit_store = lookup_hit && (|s1_wen);
	assign cnt_off = cnt[dcache_pkg::OFFSET_W-1:0];

	// stage 0 address: replay, new CPU request, or hold the last one
	always_comb begin
		if (replay) begin
			rq_addr = sv_addr;
		end else if (accept) begin
			rq_addr.addr = i_addr;
		end else begin
			rq_addr = s1_addr;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			s1_valid <= 1'b0;
			o_rvalid <= 1'b0;
		end else begin
			s1_valid <= accept || replay;
			o_rvalid <= lookup_hit;
		end
	end

	always_ff @(posedge i_clk) begin
		if (accept || replay) begin
			s1_addr <= rq_addr;
			s1_wen <= replay ? sv_wen : i_wen;
			s1_wdata <= replay ? sv_wdata : i_wdata;
		end
		if (miss) begin
			sv_addr <= s1_addr;
			sv_wen <= s1_wen;
			sv_wdata <= s1_wdata;
			sv_way <= lru_victim;
		end
		// store answers with the word as it is after the write
		if (lookup_hit) begin
			o_rdata <= merge_bytes(ds_rdata, s1_wdata, s1_wen);
		end
	end

	// line-aligned burst addresses
	always_comb begin
		rd_line = sv_addr;
		rd_line.fld.offset = '0;
		rd_line.fld.byte_sel = '0;
		wb_line = rd_line;
		wb_line.fld.tag = way_tag;
	end

	assign o_mem_rd_req = rd_req;
	assign o_mem_rd_addr = rd_line.addr;
	assign o_mem_wr_valid = wb_valid;
	assign o_mem_wr_addr = wb_line.addr;
	assign o_mem_wr_data = ds_rdata;

	dcache_ctrl_fsm u_fsm (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_lookup_valid (s1_valid),
		.i_hit          (hit),
		.i_victim_valid (victim_valid),
		.i_cnt_last     (cnt_last),
		.i_mem_rd_valid (i_mem_rd_valid),
		.o_state        (state),
		.o_busy         (o_busy),
		.o_cnt_clear    (cnt_clear),
		.o_cnt_step     (cnt_step),
		.o_sweep_en     (sweep_en),
		.o_tag_we       (tag_we),
		.o_fill_we      (fill_we),
		.o_wb_rd        (wb_rd),
		.o_wb_valid     (wb_valid),
		.o_rd_req       (rd_req),
		.o_replay       (replay)
	);

	line_word_counter u_cnt (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_clear (cnt_clear),
		.i_step  (cnt_step),
		.i_sweep (sweep_en),
		.o_count (cnt),
		.o_last  (cnt_last)
	);

	// victim way comes from the LRU bit while looking up
	tag_store u_tags (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_rd_index     (rq_addr.fld.index),
		.i_cmp_tag      (s1_addr.fld.tag),
		.i_we           (tag_we),
		.i_we_way       ((state == dcache_pkg::LOOKUP) ? lru_victim : sv_way),
		.i_wr_index     (sweep_en ? cnt : sv_addr.fld.index),
		.i_wr_tag       (sv_addr.fld.tag),
		.i_sweep        (sweep_en),
		.o_hit          (hit),
		.o_hit_way      (hit_way),
		.o_way_tag      (way_tag),
		.o_victim_valid (victim_valid)
	);

	data_store u_data (
		.i_clk       (i_clk),
		.i_rd_index  (wb_rd ? sv_addr.fld.index : rq_addr.fld.index),
		.i_rd_offset (wb_rd ? cnt_off : rq_addr.fld.offset),
		.i_we        (hit_store || fill_we),
		.i_we_way    (fill_we ? sv_way : hit_way),
		.i_wr_index  (fill_we ? sv_addr.fld.index : s1_addr.fld.index),
		.i_wr_offset (fill_we ? cnt_off : s1_addr.fld.offset),
		.i_byte_en   (fill_we ? {dcache_pkg::NUM_BYTES{1'b1}} : s1_wen),
		.i_wdata     (fill_we ? i_mem_rd_data : s1_wdata),
		.i_rd_way    (wb_valid ? sv_way : hit_way),
		.o_rdata     (ds_rdata)
	);

	lru_store u_lru (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_index      (s1_addr.fld.index),
		.i_touch      (lookup_hit),
		.i_touch_way  (hit_way),
		.o_victim_way (lru_victim)
	);

endmodule

`default_nettype wire

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model (
	input  wire                    i_clk,
	input  wire                    i_rst,
	input  wire                    i_rd_req,
	input  wire dcache_pkg::word_t i_rd_addr,
	output logic                   o_rd_valid,
	output dcache_pkg::word_t      o_rd_data,
	input  wire                    i_wr_valid,
	input  wire dcache_pkg::word_t i_wr_addr,
	input  wire dcache_pkg::word_t i_wr_data
);

	// written words only, everything else reads as its inverted address
	dcache_pkg::word_t mem [dcache_pkg::word_t];
	logic [31:0] rand_state = 32'h29a2_c3c0;
	int wr_beat;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic dcache_pkg::word_t read_word(input dcache_pkg::word_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end else begin
			return ~a;
		end
	endfunction

	// read burst, one word per pulse with random gaps
	initial begin
		dcache_pkg::word_t line;
		int gap;
		o_rd_valid = 1'b0;
		o_rd_data = '0;
		forever begin
			@(negedge i_clk);
			if (!i_rst && i_rd_req) begin
				line = i_rd_addr;
				@(posedge i_clk);
				#2;
				for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
					rand_state = xorshift32(rand_state);
					// longer wait before the first word
					gap = (w == 0) ? 32'(rand_state[2:0]) + 1 : 32'(rand_state[1:0]);
					o_rd_valid = 1'b0;
					repeat (gap) begin
						@(posedge i_clk);
						#2;
					end
					o_rd_valid = 1'b1;
					o_rd_data = read_word(line + 4 * w);
					@(posedge i_clk);
					#2;
				end
				o_rd_valid = 1'b0;
			end
		end
	end

	// write burst capture, same line address on every beat
	always @(negedge i_clk) begin
		if (i_rst || !i_wr_valid) begin
			wr_beat = 0;
		end else begin
			mem[i_wr_addr + 4 * wr_beat] = i_wr_data;
			wr_beat = wr_beat + 1;
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_dcache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;

	localparam int TIMEOUT_CYCLES = 4000;
	localparam int WAIT_LIMIT = 300;
	localparam dcache_pkg::index_t SET = 6'd26;
	localparam dcache_pkg::tag_t TAG_A = 21'h00024;
	localparam dcache_pkg::tag_t TAG_B = 21'h00135;
	localparam dcache_pkg::tag_t TAG_C = 21'h1a0f3;

	logic clk;
	logic rst;
	logic req;
	dcache_pkg::word_t addr;
	logic [dcache_pkg::NUM_BYTES-1:0] wen;
	dcache_pkg::word_t wdata;
	logic busy, rvalid, mem_rd_req, mem_rd_valid, mem_wr_valid;
	dcache_pkg::word_t rdata, mem_rd_addr, mem_rd_data, mem_wr_addr, mem_wr_data;

	int cycle_count = 0;
	int error_count = 0;
	int check_count = 0;

	// answers and write beats, each with the cycle it was seen in
	int rsp_cycle [$];
	dcache_pkg::word_t rsp_data [$];
	int wr_cycle [$];
	dcache_pkg::word_t wr_addr_q [$];
	dcache_pkg::word_t wr_data_q [$];

	// line address of every cycle with a memory read request
	dcache_pkg::word_t rd_addr_q [$];

	// expected contents of every word stored to so far
	dcache_pkg::word_t shadow [dcache_pkg::word_t];

	dcache_top dut (
		.i_clk          (clk),
		.i_rst          (rst),
		.i_req          (req),
		.i_addr         (addr),
		.i_wen          (wen),
		.i_wdata        (wdata),
		.i_mem_rd_valid (mem_rd_valid),
		.i_mem_rd_data  (mem_rd_data),
		.o_busy         (busy),
		.o_rvalid       (rvalid),
		.o_rdata        (rdata),
		.o_mem_rd_req   (mem_rd_req),
		.o_mem_rd_addr  (mem_rd_addr),
		.o_mem_wr_valid (mem_wr_valid),
		.o_mem_wr_addr  (mem_wr_addr),
		.o_mem_wr_data  (mem_wr_data)
	);

	tb_mem_model u_mem (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_rd_req   (mem_rd_req),
		.i_rd_addr  (mem_rd_addr),
		.o_rd_valid (mem_rd_valid),
		.o_rd_data  (mem_rd_data),
		.i_wr_valid (mem_wr_valid),
		.i_wr_addr  (mem_wr_addr),
		.i_wr_data  (mem_wr_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// sampled mid-cycle
	always @(negedge clk) begin
		if (rvalid) begin
			rsp_cycle.push_back(cycle_count);
			rsp_data.push_back(rdata);
		end
		if (mem_wr_valid) begin
			wr_cycle.push_back(cycle_count);
			wr_addr_q.push_back(mem_wr_addr);
			wr_data_q.push_back(mem_wr_data);
		end
		if (mem_rd_req) begin
			rd_addr_q.push_back(mem_rd_addr);
		end
	end

	initial begin
		wait (cycle_count == TIMEOUT_CYCLES);
		$display("timeout: the run was stopped after %0d cycles", TIMEOUT_CYCLES);
		$display("Something failed");
		$finish;
	end

	function automatic dcache_pkg::word_t make_addr(
		input dcache_pkg::tag_t t,
		input dcache_pkg::index_t i,
		input dcache_pkg::offset_t o
	);
		dcache_pkg::dcache_addr_u a;
		a.fld.tag = t;
		a.fld.index = i;
		a.fld.offset = o;
		a.fld.byte_sel = '0;
		return a.addr;
	endfunction

	// memory starts out as the inverted word address
	function automatic dcache_pkg::word_t expected_word(input dcache_pkg::word_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end else begin
			return ~a;
		end
	endfunction

	function automatic dcache_pkg::word_t apply_store(
		input dcache_pkg::word_t old_w,
		input dcache_pkg::word_t new_w,
		input logic [dcache_pkg::NUM_BYTES-1:0] be
	);
		dcache_pkg::word_t mask;
		mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic report_failure(input string msg);
		error_count++;
		$display("%0t: %s", $time, msg);
	endtask

	task automatic check_word(
		input string what,
		input dcache_pkg::word_t got,
		input dcache_pkg::word_t exp
	);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t: %s gave %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_line_addr(
		input string what,
		input dcache_pkg::dcache_addr_u got,
		input dcache_pkg::dcache_addr_u exp
	);
		check_count++;
		if (got.addr !== exp.addr) begin
			error_count++;
			$display("[ERROR] %0t: %s gave %h (tag %h set %0d), expected %h (tag %h set %0d)",
				$time, what, got.addr, got.fld.tag, got.fld.index,
				exp.addr, exp.fld.tag, exp.fld.index);
		end
	endtask

	// one strobe, the shadow follows stores
	task automatic strobe(
		input dcache_pkg::word_t a,
		input logic [dcache_pkg::NUM_BYTES-1:0] be,
		input dcache_pkg::word_t d,
		output int c
	);
		req = 1'b1;
		addr = a;
		wen = be;
		wdata = d;
		c = cycle_count;
		if (|be) begin
			shadow[a] = apply_store(expected_word(a), d, be);
		end
		next_cycle();
		req = 1'b0;
	endtask

	task automatic get_response(output int c, output dcache_pkg::word_t d);
		int waited;
		waited = 0;
		while (rsp_cycle.size() == 0 && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (rsp_cycle.size() == 0) begin
			report_failure("no o_rvalid pulse arrived");
			c = -1;
			d = '0;
		end else begin
			c = rsp_cycle.pop_front();
			d = rsp_data.pop_front();
		end
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		@(negedge clk);
		while (busy && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (busy) begin
			report_failure("o_busy stayed high");
		end
		next_cycle();
	endtask

	// one single-cycle read request per miss, at the line of the missed word
	task automatic single_refill_request(input dcache_pkg::word_t a);
		dcache_pkg::dcache_addr_u got;
		dcache_pkg::dcache_addr_u exp;
		exp.addr = a - (a % (4 * dcache_pkg::WORDS_PER_LINE));
		if (rd_addr_q.size() != 1) begin
			report_failure($sformatf("%0d memory read request cycles for one miss instead of 1",
				rd_addr_q.size()));
		end
		if (rd_addr_q.size() != 0) begin
			got.addr = rd_addr_q[0];
			check_line_addr("refill address", got, exp);
		end
		rd_addr_q.delete();
	endtask

	task automatic load_miss(input dcache_pkg::word_t a);
		int c;
		int rc;
		dcache_pkg::word_t d;
		wait_idle();
		strobe(a, '0, '0, c);
		@(negedge clk);
		if (!busy) begin
			report_failure("o_busy did not rise in the compare cycle of a miss");
		end
		get_response(rc, d);
		check_word($sformatf("miss load %h", a), d, expected_word(a));
		single_refill_request(a);
		@(negedge clk);
		if (cycle_count != rc + 1 || busy) begin
			report_failure("o_busy did not fall in the cycle after o_rvalid");
		end
		next_cycle();
	endtask

	// hits on back-to-back cycles, each answered 2 cycles later
	task automatic load_hits(input dcache_pkg::word_t a, input int n);
		int issued [8];
		int rc;
		dcache_pkg::word_t d;
		wait_idle();
		for (int i = 0; i < n; i++) begin
			strobe(a + 4 * i, '0, '0, issued[i]);
		end
		for (int i = 0; i < n; i++) begin
			get_response(rc, d);
			if (rc != issued[i] + 2) begin
				report_failure($sformatf("hit answer in cycle %0d, strobe was in %0d",
					rc, issued[i]));
			end
			check_word($sformatf("hit load %h", a + 4 * i), d, expected_word(a + 4 * i));
		end
	endtask

	task automatic store_then_load(
		input dcache_pkg::word_t a,
		input logic [dcache_pkg::NUM_BYTES-1:0] be,
		input dcache_pkg::word_t d
	);
		int sc;
		int lc;
		int rc;
		dcache_pkg::word_t rd;
		wait_idle();
		strobe(a, be, d, sc);
		strobe(a, '0, '0, lc);
		get_response(rc, rd);
		if (rc != sc + 2) begin
			report_failure("store answer not 2 cycles after its strobe");
		end
		check_word("store answer", rd, expected_word(a));
		get_response(rc, rd);
		if (rc != lc + 2) begin
			report_failure("forwarded load answer not 2 cycles after its strobe");
		end
		check_word("forwarded load", rd, expected_word(a));
	endtask

	task automatic expect_no_write_burst();
		if (wr_cycle.size() != 0) begin
			report_failure("a write burst came out for an invalid victim");
			wr_cycle.delete();
			wr_addr_q.delete();
			wr_data_q.delete();
		end
	endtask

	task automatic compare_write_burst(input dcache_pkg::word_t line);
		dcache_pkg::dcache_addr_u got;
		dcache_pkg::dcache_addr_u exp;
		exp.addr = line;
		if (wr_cycle.size() != dcache_pkg::WORDS_PER_LINE) begin
			report_failure($sformatf("write burst had %0d beats instead of 8",
				wr_cycle.size()));
		end else begin
			for (int i = 0; i < dcache_pkg::WORDS_PER_LINE; i++) begin
				got.addr = wr_addr_q[i];
				check_line_addr("write burst address", got, exp);
				check_word($sformatf("write beat %0d", i), wr_data_q[i],
					expected_word(line + 4 * i));
				if (wr_cycle[i] != wr_cycle[0] + i) begin
					report_failure("write beats not on consecutive cycles");
				end
			end
		end
		wr_cycle.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
	endtask

	task automatic reset_and_first_miss();
		int waited;
		waited = 0;
		@(negedge clk);
		if (rvalid || mem_rd_req || mem_wr_valid) begin
			report_failure("o_rvalid, o_mem_rd_req or o_mem_wr_valid high after reset");
		end
		while (busy && waited < 70) begin
			@(negedge clk);
			waited++;
		end
		if (busy) begin
			report_failure("o_busy still high 70 cycles after reset");
		end
		next_cycle();
		load_miss(make_addr(TAG_A, SET, 3'd3));
		expect_no_write_burst();
	endtask

	task automatic repeated_hits();
		load_hits(make_addr(TAG_A, SET, 3'd3), 1);
		load_hits(make_addr(TAG_A, SET, 3'd0), dcache_pkg::WORDS_PER_LINE);
	endtask

	task automatic store_with_forwarding();
		store_then_load(make_addr(TAG_A, SET, 3'd2), 4'b0110, 32'ha5c3_1e77);
		store_then_load(make_addr(TAG_A, SET, 3'd7), 4'b1001, 32'h5af0_0f96);
	endtask

	// line A is least recently used once B has been filled
	task automatic evict_lru_line();
		load_miss(make_addr(TAG_B, SET, 3'd5));
		expect_no_write_burst();
		load_miss(make_addr(TAG_C, SET, 3'd1));
		compare_write_burst(make_addr(TAG_A, SET, 3'd0));
	endtask

	task automatic reload_evicted_line();
		load_miss(make_addr(TAG_A, SET, 3'd2));
		compare_write_burst(make_addr(TAG_B, SET, 3'd0));
		load_hits(make_addr(TAG_A, SET, 3'd7), 1);
	endtask

	initial begin
		rst = 1'b1;
		req = 1'b0;
		addr = '0;
		wen = '0;
		wdata = '0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		reset_and_first_miss();
		repeated_hits();
		store_with_forwarding();
		evict_lru_line();
		reload_evicted_line();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/dcache_pkg.sv
rtl/dcache_ctrl_fsm.sv
rtl/line_word_counter.sv
rtl/tag_store.sv
rtl/data_store.sv
rtl/lru_store.sv
rtl/dcache_top.sv
sim/tb_mem_model.sv
sim/tb_dcache.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_dcache

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): tb.f $(wildcard rtl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing -f tb.f --top-module tb_dcache -Mdir obj_dir -o Vtb_dcache

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
